//--- list.f
rtl/bus_pkg.sv
rtl/io_pkg.sv
rtl/startup_timer.sv
rtl/wb_io_fsm.sv
rtl/led_port.sv
rtl/uart_pins.sv
rtl/board_io.sv
tests/tb_board_io.sv

//--- tests/tb_board_io.sv
// ==================================================
// Testbench for the board I/O block: startup hold-off,
// then a table of bus reads and writes checked on pins
// ==================================================
module tb_board_io;

   localparam int NUM_ENTRIES  = 15;
   localparam int ACK_TIMEOUT  = 10;   // Cycles a strobe may wait once running
   localparam int TICK_GAP     = 3;    // Cycles per slow tick
   localparam int STARTUP_CYC  = 5 + io_pkg::STARTUP_TICKS * TICK_GAP + 10;
   localparam int WATCHDOG_CYC = NUM_ENTRIES * 20 + STARTUP_CYC;

   // One table row
   typedef struct packed {
      logic        wr;        // Write when high, else read
      logic        b2b;       // Issued right after the previous ack
      logic [31:0] adr;
      logic [3:0]  sel;
      logic [31:0] dat;
      logic        rx;        // rx level for this row
      logic [3:0]  pins;      // tx, blue, green, red
      logic [31:0] rd_word;   // Expected read data
   } entry_t;

   logic             CLK_I = 1'b0;
   logic             rst_n;
   bus_pkg::wb_req_t bus_req;
   logic             slow_tick;
   logic             rx;
   bus_pkg::wb_rsp_t bus_rsp;
   logic             hf_en;
   logic             led_red;
   logic             led_green;
   logic             led_blue;
   logic             tx;

   entry_t      entries [NUM_ENTRIES];
   integer      seed    = 32'h8be4_a432;
   int          errors  = 0;
   int          checks  = 0;
   int          ack_cnt = 0;
   logic [31:0] rdata;
   logic        next_b2b;

   board_io u_board_io (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .bus_req   (bus_req),
      .slow_tick (slow_tick),
      .rx        (rx),
      .bus_rsp   (bus_rsp),
      .hf_en     (hf_en),
      .led_red   (led_red),
      .led_green (led_green),
      .led_blue  (led_blue),
      .tx        (tx)
   );

   always #4 CLK_I = ~CLK_I;   // Period 8

   // Counts acks seen during the previous cycle
   always @(posedge CLK_I) begin
      if (bus_rsp.ack === 1'b1) ack_cnt <= ack_cnt + 1;
   end

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   // Inputs change one unit after the edge
   task automatic next_cycle();
      @(posedge CLK_I);
      #1;
   endtask

   task automatic pulse_tick();
      slow_tick = 1'b1;
      next_cycle();
      slow_tick = 1'b0;
   endtask

   task automatic start_req(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat);
      bus_req = '{stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
   endtask

   // Holds the strobe until ack, then drops it
   task automatic wait_ack(output logic [31:0] dat);
      int   n;
      logic got;
      n   = 0;
      got = 1'b0;
      while (!got && n < ACK_TIMEOUT) begin
         next_cycle();
         n++;
         got = (bus_rsp.ack === 1'b1);
      end
      dat = bus_rsp.dat;
      bus_req.stb = 1'b0;
      bus_req.we  = 1'b0;
      if (!got) begin
         errors++;
         $display("Error: no bus acknowledge within %0d cycles at time %0t", ACK_TIMEOUT, $time);
      end
   endtask

   task automatic set_entry(input int idx, input logic wr, input logic b2b,
                            input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat);
      entry_t e;
      e     = '0;
      e.wr  = wr;
      e.b2b = b2b;
      e.adr = adr;
      e.sel = sel;
      e.dat = dat;
      entries[idx] = e;
   endtask

   task automatic build_table();
      set_entry(0,  1, 0, 32'h4, 4'hf, 32'h0000_0005);   // LED red and blue
      set_entry(1,  0, 0, 32'h0, 4'hf, 32'h0);
      set_entry(2,  1, 0, 32'h8, 4'hf, 32'h0000_0000);   // tx low
      set_entry(3,  1, 0, 32'h8, 4'hf, 32'h0000_0001);
      set_entry(4,  1, 0, 32'h4, 4'h8, 32'h8000_0002);   // Blue from rx
      set_entry(5,  0, 0, 32'h0, 4'hf, 32'h0);
      set_entry(6,  0, 0, 32'h0, 4'hf, 32'h0);
      set_entry(7,  1, 0, 32'h4, 4'h7, 32'h0000_0001);   // Flag lane off
      set_entry(8,  0, 0, 32'h0, 4'hf, 32'h0);
      set_entry(9,  1, 0, 32'h4, 4'hf, 32'h0000_0004);   // Flag cleared
      set_entry(10, 1, 0, 32'h4, 4'hf, 32'h0000_0005);
      set_entry(11, 1, 1, 32'h8, 4'hf, 32'h0000_0000);   // Back to back
      set_entry(12, 1, 1, 32'h4, 4'hf, 32'h0000_0002);
      set_entry(13, 0, 0, 32'h0, 4'hf, 32'h0);
      set_entry(14, 1, 0, 32'h8, 4'hf, 32'h0000_0001);
   endtask

   // Reference model of the LED and tx registers
   task automatic predict_table();
      entry_t      e;
      logic [31:0] rnd;
      logic        prev_rx;
      logic        m_red;
      logic        m_green;
      logic        m_blue;
      logic        m_flag;
      logic        m_tx;
      prev_rx = 1'b1;
      m_red   = 1'b0;
      m_green = 1'b0;
      m_blue  = 1'b0;
      m_flag  = 1'b0;
      m_tx    = 1'b1;   // Idle line
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         e   = entries[i];
         rnd = $random(seed);
         e.rx = e.b2b ? prev_rx : rnd[0];
         if (m_flag) m_blue = e.rx;   // Tracking rx
         if (e.wr && e.adr[bus_pkg::LED_ADR_BIT]) begin
            m_red   = e.dat[0];
            m_green = e.dat[1];
            if (!m_flag) m_blue = e.dat[2];
            if (e.sel[3]) m_flag = e.dat[31];
            if (m_flag) m_blue = e.rx;
         end
         if (e.wr && e.adr[bus_pkg::TX_ADR_BIT]) m_tx = e.dat[0];
         e.pins    = {m_tx, m_blue, m_green, m_red};
         e.rd_word = '0;
         e.rd_word[3:0] = {m_flag, m_blue, m_green, m_red};
         e.rd_word[io_pkg::RX_STAT_BIT]    = e.rx;
         e.rd_word[io_pkg::READY_STAT_BIT] = 1'b1;
         entries[i] = e;
         prev_rx = e.rx;
      end
   endtask

   initial begin
      #(WATCHDOG_CYC * 8);
      $display("Error: watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYC);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      entry_t e;
      rst_n     = 1'b0;
      bus_req   = '0;
      slow_tick = 1'b0;
      rx        = 1'b1;
      build_table();
      predict_table();
      repeat (5) @(posedge CLK_I);
      #1 rst_n = 1'b1;

      // Idle state out of reset
      compare({28'b0, tx, led_blue, led_green, led_red}, 32'h8, "pins after reset");
      compare(hf_en, 0, "hf_en after reset");

      // Read held off until the eighth tick
      start_req(1'b0, 32'h0, 4'hf, 32'h0);
      for (int i = 1; i <= io_pkg::STARTUP_TICKS; i++) begin
         pulse_tick();
         compare(hf_en, (i == io_pkg::STARTUP_TICKS), $sformatf("hf_en after tick %0d", i));
         if (i < io_pkg::STARTUP_TICKS) begin
            compare(ack_cnt, 0, $sformatf("ack before tick %0d", i + 1));
            repeat (TICK_GAP - 1) next_cycle();
         end
      end
      wait_ack(rdata);
      compare(rdata, (1 << io_pkg::READY_STAT_BIT) | (1 << io_pkg::RX_STAT_BIT),
              "read after startup");

      for (int i = 0; i < NUM_ENTRIES; i++) begin
         e = entries[i];
         if (!e.b2b) begin
            rx = e.rx;
            repeat (4) next_cycle();   // Sync plus blue follow
         end
         start_req(e.wr, e.adr, e.sel, e.dat);
         wait_ack(rdata);
         if (!e.wr) compare(rdata, e.rd_word, $sformatf("entry %0d read word", i));
         next_b2b = 1'b0;
         if (i + 1 < NUM_ENTRIES) next_b2b = entries[i + 1].b2b;
         if (!next_b2b) begin
            repeat (2) next_cycle();
            compare({28'b0, tx, led_blue, led_green, led_red}, {28'b0, e.pins},
                    $sformatf("entry %0d pins", i));
         end
      end

      // Startup read plus one per row
      next_cycle();
      compare(ack_cnt, NUM_ENTRIES + 1, "total ack count");

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- rtl/board_io.sv
// ==================================================
// Board I/O top: startup timer, bus FSM, LED port and
// serial pins between the core bus and the board
// ==================================================
module board_io (
   input  logic             CLK_I,
   input  logic             rst_n,
   input  bus_pkg::wb_req_t bus_req,
   input  logic             slow_tick,   // Slow oscillator pulse
   input  logic             rx,
   output bus_pkg::wb_rsp_t bus_rsp,
   output logic             hf_en,       // Fast clock enable
   output logic             led_red,
   output logic             led_green,
   output logic             led_blue,
   output logic             tx
);

   logic                           ready;
   logic                           rx_sync;
   logic [io_pkg::LED_STATE_W-1:0] led_state;
   logic                           led_we;
   logic                           led_flag_we;
   logic                           tx_we;
   io_pkg::io_word_u               wr_word;   // Shared by both ports

   startup_timer u_startup_timer (
      .CLK_I     (CLK_I),
      .rst_n     (rst_n),
      .slow_tick (slow_tick),
      .ready     (ready)
   );

   assign hf_en = ready;   // Oscillator released with the bus

   wb_io_fsm u_wb_io_fsm (
      .CLK_I       (CLK_I),
      .rst_n       (rst_n),
      .ready       (ready),
      .bus_req     (bus_req),
      .rx_sync     (rx_sync),
      .led_state   (led_state),
      .bus_rsp     (bus_rsp),
      .led_we      (led_we),
      .led_flag_we (led_flag_we),
      .tx_we       (tx_we),
      .wr_word     (wr_word)
   );

   led_port u_led_port (
      .CLK_I       (CLK_I),
      .rst_n       (rst_n),
      .led_we      (led_we),
      .led_flag_we (led_flag_we),
      .wr_word     (wr_word),
      .rx_sync     (rx_sync),
      .led_state   (led_state),
      .led_red     (led_red),
      .led_green   (led_green),
      .led_blue    (led_blue)
   );

   uart_pins u_uart_pins (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .rx      (rx),
      .tx_we   (tx_we),
      .wr_word (wr_word),
      .rx_sync (rx_sync),
      .tx      (tx)
   );

endmodule

//--- rtl/uart_pins.sv
// ==================================================
// Serial pins: rx is synchronized into the clock
// domain, tx is a bit-banged register, idle high
// ==================================================
module uart_pins (
   input  logic             CLK_I,
   input  logic             rst_n,
   input  logic             rx,        // Asynchronous pin
   input  logic             tx_we,
   input  io_pkg::io_word_u wr_word,
   output logic             rx_sync,
   output logic             tx
);

   logic rx_meta;   // First stage, may go metastable

   // Two flops, so rx_sync lags the pin by two edges
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;   // Line idles high
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   // Transmit level
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         tx <= 1'b1;        // Serial idle
      end else if (tx_we) begin
         tx <= wr_word.tx.level;
      end
   end

endmodule

//--- rtl/led_port.sv
// ==================================================
// LED control registers; blue can be switched to
// mirror the synchronized serial input
// ==================================================
module led_port (
   input  logic                           CLK_I,
   input  logic                           rst_n,
   input  logic                           led_we,
   input  logic                           led_flag_we,  // Top byte lane
   input  io_pkg::io_word_u               wr_word,
   input  logic                           rx_sync,
   output logic [io_pkg::LED_STATE_W-1:0] led_state,
   output logic                           led_red,
   output logic                           led_green,
   output logic                           led_blue
);

   logic blue_from_rx;   // Blue source select

   // Red, green and the select flag
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         led_red      <= 1'b0;
         led_green    <= 1'b0;
         blue_from_rx <= 1'b0;
      end else begin
         if (led_we) begin
            led_red   <= wr_word.led.red;
            led_green <= wr_word.led.green;
         end
         if (led_flag_we) blue_from_rx <= wr_word.led.blue_from_rx;
      end
   end

   // Blue tracks rx while the flag is set
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         led_blue <= 1'b0;
      end else if (blue_from_rx) begin
         led_blue <= rx_sync;              // One edge behind rx_sync
      end else if (led_we) begin
         led_blue <= wr_word.led.blue;
      end
   end

   // Same order as the write word
   assign led_state = {blue_from_rx, led_blue, led_green, led_red};

endmodule

//--- rtl/wb_io_fsm.sv
// ==================================================
// Bus handshake for the I/O block: waits for startup,
// acks each strobe once and decodes write enables
// ==================================================
module wb_io_fsm (
   input  logic                           CLK_I,
   input  logic                           rst_n,
   input  logic                           ready,      // From startup timer
   input  bus_pkg::wb_req_t               bus_req,
   input  logic                           rx_sync,
   input  logic [io_pkg::LED_STATE_W-1:0] led_state,  // Flag and colours
   output bus_pkg::wb_rsp_t               bus_rsp,
   output logic                           led_we,
   output logic                           led_flag_we,
   output logic                           tx_we,
   output io_pkg::io_word_u               wr_word
);

   typedef enum logic [1:0] {
      WAIT_READY,   // Clock not yet trusted
      IDLE,         // Sampling stb
      ACK           // One-cycle acknowledge
   } state_t;

   state_t      state;
   state_t      state_nxt;
   logic        take;       // Strobe accepted this cycle
   logic [31:0] stat_word;
   logic [31:0] rd_dat;     // Read data held for the ack cycle

   always_comb begin
      state_nxt = state;
      case (state)
         WAIT_READY: if (ready) state_nxt = IDLE;
         IDLE:       if (bus_req.stb) state_nxt = ACK;
         ACK:        state_nxt = IDLE;   // Master may restrobe next cycle
         default:    state_nxt = WAIT_READY;
      endcase
   end

   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         state <= WAIT_READY;
      end else begin
         state <= state_nxt;
      end
   end

   assign take = (state == IDLE) && bus_req.stb;

   // Enables fire on the same edge that raises ack
   assign led_we      = take && bus_req.we && bus_req.adr[bus_pkg::LED_ADR_BIT];
   assign led_flag_we = led_we && bus_req.sel[3];   // Top byte holds the flag
   assign tx_we       = take && bus_req.we && bus_req.adr[bus_pkg::TX_ADR_BIT];
   assign wr_word     = bus_req.dat;

   // Status word
   always_comb begin
      stat_word = '0;
      stat_word[io_pkg::LED_STATE_W-1:0] = led_state;
      stat_word[io_pkg::RX_STAT_BIT]     = rx_sync;
      stat_word[io_pkg::READY_STAT_BIT]  = ready;
   end

   // Captured when the read is taken
   always_ff @(posedge CLK_I) begin
      if (take && !bus_req.we) begin
         rd_dat <= stat_word;
      end
   end

   assign bus_rsp = '{ack: (state == ACK), dat: rd_dat};

   a_ack_single: assert property (
      @(posedge CLK_I) disable iff (!rst_n)
      bus_rsp.ack |=> !bus_rsp.ack
   ) else $error("ack held for more than one cycle");

   // Master must not address both registers at once
   a_we_onehot: assert property (
      @(posedge CLK_I) disable iff (!rst_n)
      !(led_we && tx_we)
   ) else $error("LED and tx write enables overlap");

endmodule

//--- rtl/startup_timer.sv
// ==================================================
// Counts slow-oscillator ticks after reset and raises
// ready, which enables the fast clock and the bus
// ==================================================
module startup_timer (
   input  logic CLK_I,
   input  logic rst_n,
   input  logic slow_tick,   // One pulse per slow period
   output logic ready
);

   logic [3:0] tick_cnt;

   // Saturating count, stops once the target is hit
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         tick_cnt <= '0;
      end else if (slow_tick && !ready) begin
         tick_cnt <= tick_cnt + 4'd1;
      end
   end

   // High from the edge that takes the last tick
   assign ready = (tick_cnt == 4'(io_pkg::STARTUP_TICKS));

   // Oscillator enable must stay on once released
   a_ready_sticky: assert property (
      @(posedge CLK_I) disable iff (!rst_n)
      ready |=> ready
   ) else $error("ready dropped outside reset");

endmodule

//--- rtl/io_pkg.sv
// ==================================================
// Register word layout, startup count and status bit
// positions shared by the I/O state machine and ports
// ==================================================
package io_pkg;

   // Slow ticks before the fast clock runs
   localparam int STARTUP_TICKS = 8;

   // Flag plus three colours
   localparam int LED_STATE_W = 4;

   // Read word, LED state sits in the low nibble
   localparam int RX_STAT_BIT    = 8;   // Synchronized rx level
   localparam int READY_STAT_BIT = 9;   // Startup done

   // LED view of a write word
   typedef struct packed {
      logic        blue_from_rx;   // Bit 31, blue follows rx
      logic [27:0] rsvd;
      logic        blue;           // Bit 2
      logic        green;          // Bit 1
      logic        red;            // Bit 0
   } led_view_t;

   // Transmit view of the same word
   typedef struct packed {
      logic [30:0] rsvd;
      logic        level;          // Bit 0 drives tx
   } tx_view_t;

   // One write word, decoded by address
   typedef union packed {
      led_view_t led;
      tx_view_t  tx;
   } io_word_u;

endpackage

//--- rtl/bus_pkg.sv
// ==================================================
// Bus request and response types of the board I/O block
// and the address bits that pick its two write registers
// ==================================================
package bus_pkg;

   // Address decode, one bit per register
   localparam int LED_ADR_BIT = 2;   // LED control word
   localparam int TX_ADR_BIT  = 3;   // Serial transmit level

   // Master side, held stable from stb until ack
   typedef struct packed {
      logic        stb;   // Cycle request
      logic        we;    // Write when high
      logic [3:0]  sel;   // Byte lanes
      logic [31:0] adr;
      logic [31:0] dat;   // Write data
   } wb_req_t;

   // Slave side
   typedef struct packed {
      logic        ack;   // One cycle per strobe
      logic [31:0] dat;   // Read data, valid with ack
   } wb_rsp_t;

endpackage
